// ==== Makefile ====
# Verilator build and run for the FMA unit testbench

VERILATOR ?= verilator
TOP       ?= fma_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Finished with errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/fma_tb.sv ====
`timescale 1ns/100ps

module fma_tb;

    localparam int num_lanes   = 2;
    localparam int latency_mul = 3;
    localparam int n_req       = 2000;

    typedef struct packed {
        logic [fma_pkg::data_w-1:0] res;
        logic [1:0]                 flg;        // {of, nx}
    } lane_exp_t;

    typedef struct packed {
        lane_exp_t [num_lanes-1:0] lane;
        logic [fma_pkg::tag_w-1:0] tag;
    } expect_t;

    logic                                      clk = 1'b0;
    logic                                      rst;
    logic                                      valid_in;
    logic                                      ready_in;
    logic                                      ready_out;
    logic                                      valid_out;
    fma_pkg::fma_op_e                          op;
    logic [2:0]                                frm;
    logic [fma_pkg::tag_w-1:0]                 tag_in;
    logic [fma_pkg::tag_w-1:0]                 tag_out;
    logic [num_lanes-1:0][fma_pkg::data_w-1:0] dataa;
    logic [num_lanes-1:0][fma_pkg::data_w-1:0] datab;
    logic [num_lanes-1:0][fma_pkg::data_w-1:0] datac;
    logic [num_lanes-1:0][fma_pkg::data_w-1:0] result;
    fma_pkg::fma_flags_t [num_lanes-1:0]       flags;

    logic [31:0] lfsr_state = 32'd7;
    expect_t     exp_q [$];                     // oldest in-flight request at the front
    logic        held = 1'b0;
    expect_t     held_out;

    always #4 clk = ~clk;

    fma_unit #(.num_lanes(num_lanes), .latency_mul(latency_mul)) u_dut (
        .clk(clk), .rst(rst), .valid_in(valid_in), .ready_in(ready_in),
        .op(op), .frm(frm), .tag_in(tag_in),
        .dataa(dataa), .datab(datab), .datac(datac),
        .ready_out(ready_out), .valid_out(valid_out),
        .result(result), .flags(flags), .tag_out(tag_out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b          = lfsr_state[0];
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
            v          = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic [15:0] pick_operand();
        logic [1:0]  sel;
        logic [15:0] v;
        sel = 2'(lfsr_bits(2));
        v   = 16'(lfsr_bits(16));
        if (sel == 2'd0) begin
            v = {v[15], {7{~v[15]}}, v[7:0]};   // close to +-128.0
        end else if (sel != 2'd1) begin
            v = {{5{v[10]}}, v[10:0]};          // small and mostly in range
        end
        return v;
    endfunction

    task automatic drive_random();
        logic [2:0] o;
        valid_in  <= (4'(lfsr_bits(4)) < 4'd11);   // about 70 %
        ready_out <= (2'(lfsr_bits(2)) != 2'd0);
        o = 3'(lfsr_bits(3));
        if (o == 3'd7) begin
            o = fma_pkg::op_madd;
        end
        op     <= fma_pkg::fma_op_e'(o);
        frm    <= 3'(lfsr_bits(3));                 // 4..7 act as rne
        tag_in <= 4'(lfsr_bits(4));
        for (int i = 0; i < num_lanes; i++) begin
            dataa[i] <= pick_operand();
            datab[i] <= pick_operand();
            datac[i] <= pick_operand();
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic lane_exp_t model_lane(input logic [2:0] opc, input logic [2:0] rm,
                                             input logic [15:0] x, input logic [15:0] y,
                                             input logic [15:0] z);
        logic signed [15:0] a;
        logic signed [15:0] b;
        logic signed [15:0] c;
        longint             sum;
        longint             q;
        longint             r;
        longint             drop;
        lane_exp_t          e;
        a = x;
        b = y;
        c = z;
        case (opc)
            fma_pkg::op_add: begin
                a = 16'sh0100;                  // 1.0
                c = y;
                b = x;
            end
            fma_pkg::op_sub: begin
                a = 16'sh0100;
                b = x;
                c = -y;
            end
            fma_pkg::op_mul:   c = '0;
            fma_pkg::op_msub:  c = -z;
            fma_pkg::op_nmsub: a = -x;
            fma_pkg::op_nmadd: begin
                a = -x;
                c = -z;
            end
            default: ;
        endcase
        sum  = longint'(a) * longint'(b) + longint'(c) * 256;
        q    = sum >>> 8;                       // floor
        drop = sum & 255;
        case (rm)
            fma_pkg::rm_rtz: r = (sum < 0 && drop != 0) ? q + 1 : q;
            fma_pkg::rm_rdn: r = q;
            fma_pkg::rm_rup: r = (drop != 0) ? q + 1 : q;
            default:         r = (drop > 128 || (drop == 128 && q[0])) ? q + 1 : q;
        endcase
        e.flg = {(r > 32767 || r < -32768), (drop != 0)};
        if (r > 32767) begin
            e.res = 16'h7fff;
        end else if (r < -32768) begin
            e.res = 16'h8000;
        end else begin
            e.res = r[15:0];
        end
        return e;
    endfunction

    function automatic expect_t model_request();
        expect_t e;
        for (int i = 0; i < num_lanes; i++) begin
            e.lane[i] = model_lane(op, frm, dataa[i], datab[i], datac[i]);
        end
        e.tag = tag_in;
        return e;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("error at %0t: %s is 0x%0h, expected 0x%0h",
                                $time, name, got, want));
        end
    endtask

    task automatic compare_outputs(input expect_t got, input expect_t want, input string when);
        for (int i = 0; i < num_lanes; i++) begin
            check_value($sformatf("result[%0d]%s", i, when), 32'(got.lane[i].res),
                        32'(want.lane[i].res));
            check_value($sformatf("flags[%0d]%s", i, when), 32'(got.lane[i].flg),
                        32'(want.lane[i].flg));
        end
        check_value({"tag_out", when}, 32'(got.tag), 32'(want.tag));
    endtask

    // scoreboard sees the pre-edge values
    always @(posedge clk) begin
        expect_t seen;
        expect_t want;
        for (int i = 0; i < num_lanes; i++) begin
            seen.lane[i].res = result[i];
            seen.lane[i].flg = flags[i];
        end
        seen.tag = tag_out;
        if (!rst) begin
            if (held) begin
                check_value("valid_out while stalled", 32'(valid_out), 32'd1);
                compare_outputs(seen, held_out, " while stalled");
            end
            if (valid_in && ready_in) begin
                exp_q.push_back(model_request());
            end
            if (valid_out && ready_out) begin
                if (exp_q.size() == 0) begin
                    abort_run("a response came out with no request outstanding");
                end else begin
                    want = exp_q.pop_front();
                    compare_outputs(seen, want, "");
                end
            end
            held     = valid_out && !ready_out;
            held_out = seen;
        end
    end

    initial begin
        int sent;
        int cycles;
        int lat;
        rst       = 1'b1;
        valid_in  = 1'b0;
        ready_out = 1'b0;
        op        = fma_pkg::op_madd;
        frm       = 3'd0;
        tag_in    = '0;
        dataa     = '0;
        datab     = '0;
        datac     = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("valid_out", 32'(valid_out), 32'd0);
        check_value("ready_in", 32'(ready_in), 32'd1);
        ready_out <= 1'b1;
        valid_in  <= 1'b1;                      // one request to time the pipe
        tag_in    <= 4'h5;
        dataa     <= {16'h0180, 16'hfe40};
        datab     <= {16'h0240, 16'h0130};
        datac     <= {16'h0010, 16'hff00};
        @(posedge clk);
        valid_in <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            if (lat > 20) begin
                abort_run("timeout: the first request never reached the outputs");
            end
        end while (!valid_out);
        check_value("latency", 32'(lat), 32'(2 + latency_mul));

        sent   = 0;
        cycles = 0;
        while (sent < n_req) begin
            if (cycles > 20 * n_req) begin
                abort_run("timeout: random requests were not accepted in time");
            end
            drive_random();
            @(posedge clk);
            cycles++;
            if (valid_in && ready_in) begin
                sent++;
            end
        end
        valid_in  <= 1'b0;
        ready_out <= 1'b1;

        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 50 * latency_mul) begin
                abort_run("timeout: responses still outstanding after the last request");
            end
        end while (exp_q.size() != 0);
        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== sim.f ====
source/fma_pkg.sv
source/fma_decode.sv
source/fma_lane.sv
source/fma_execute.sv
source/fma_result.sv
source/fma_unit.sv
bench/fma_tb.sv

// ==== source/fma_decode.sv ====
`timescale 1ns/100ps

module fma_decode #(
    parameter int num_lanes = 2
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         enable,
    input  logic                                         valid_in,
    input  fma_pkg::fma_op_e                             op,
    input  logic [2:0]                                   frm,
    input  logic [fma_pkg::tag_w-1:0]                    tag_in,
    input  logic [num_lanes-1:0][fma_pkg::data_w-1:0]    dataa,
    input  logic [num_lanes-1:0][fma_pkg::data_w-1:0]    datab,
    input  logic [num_lanes-1:0][fma_pkg::data_w-1:0]    datac,
    output fma_pkg::lane_opnd_t [num_lanes-1:0]          opnd,
    output fma_pkg::pipe_ctl_t                           ctl
);

    fma_pkg::lane_opnd_t [num_lanes-1:0] steer;
    logic                                valid_q;
    fma_pkg::round_e                     rm_q;
    logic [fma_pkg::tag_w-1:0]           tag_q;

    // operand steering, negation wraps on the most negative value
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            steer[i].a = dataa[i];
            steer[i].b = datab[i];
            steer[i].c = datac[i];
            case (op)
                fma_pkg::op_add: begin
                    steer[i].a = fma_pkg::one_q;   // a*b becomes 1.0 * dataa
                    steer[i].b = dataa[i];
                    steer[i].c = datab[i];
                end
                fma_pkg::op_sub: begin
                    steer[i].a = fma_pkg::one_q;
                    steer[i].b = dataa[i];
                    steer[i].c = -datab[i];
                end
                fma_pkg::op_mul:   steer[i].c = '0;
                fma_pkg::op_msub:  steer[i].c = -datac[i];
                fma_pkg::op_nmsub: steer[i].a = -dataa[i];
                fma_pkg::op_nmadd: begin
                    steer[i].a = -dataa[i];
                    steer[i].c = -datac[i];
                end
                default: ;                          // madd
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (enable) begin
            valid_q <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            opnd  <= steer;
            rm_q  <= fma_pkg::round_e'(frm);     // unknown codes carried as is
            tag_q <= tag_in;
        end
    end

    assign ctl = '{valid: valid_q, rm: rm_q, tag: tag_q};

endmodule

// ==== source/fma_execute.sv ====
`timescale 1ns/100ps

module fma_execute #(
    parameter int num_lanes   = 2,
    parameter int latency_mul = 3
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         enable,
    input  fma_pkg::lane_opnd_t [num_lanes-1:0]          opnd_in,
    input  fma_pkg::pipe_ctl_t                           ctl_in,
    output logic [num_lanes-1:0][fma_pkg::acc_w-1:0]     acc,
    output fma_pkg::pipe_ctl_t                           ctl_out
);

    logic [latency_mul-1:0]    valid_q;
    fma_pkg::round_e           rm_q  [latency_mul];
    logic [fma_pkg::tag_w-1:0] tag_q [latency_mul];

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        fma_lane #(
            .latency_mul (latency_mul)
        ) u_lane (
            .clk    (clk),
            .enable (enable),
            .opnd   (opnd_in[i]),
            .acc    (acc[i])
        );
    end

    // control rides alongside the lanes
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q <= {valid_q[latency_mul-1:0] << 1} | latency_mul'(ctl_in.valid);
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            rm_q[0]  <= ctl_in.rm;
            tag_q[0] <= ctl_in.tag;
            for (int i = 1; i < latency_mul; i++) begin
                rm_q[i]  <= rm_q[i-1];
                tag_q[i] <= tag_q[i-1];
            end
        end
    end

    assign ctl_out = '{
        valid: valid_q[latency_mul-1],
        rm:    rm_q[latency_mul-1],
        tag:   tag_q[latency_mul-1]
    };

endmodule

// ==== source/fma_lane.sv ====
`timescale 1ns/100ps

module fma_lane #(
    parameter int latency_mul = 3
) (
    input  logic                              clk,
    input  logic                              enable,
    input  fma_pkg::lane_opnd_t               opnd,
    output logic signed [fma_pkg::acc_w-1:0]  acc
);

    logic signed [fma_pkg::acc_w-1:0] prod;
    logic signed [fma_pkg::acc_w-1:0] addend;
    logic signed [fma_pkg::acc_w-1:0] sum;
    logic signed [fma_pkg::acc_w-1:0] stage [latency_mul];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // multiply-add in 16.16
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // q8.8 * q8.8 already lands on the 16.16 point
    assign prod   = $signed(opnd.a) * $signed(opnd.b);

    // c sign extended before the shift, aligns to 16.16
    assign addend = $signed(opnd.c) <<< fma_pkg::frac_w;

    assign sum    = prod + addend;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fixed latency chain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (enable) begin
            stage[0] <= sum;
            for (int i = 1; i < latency_mul; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign acc = stage[latency_mul-1];         // holds while stalled

endmodule

// ==== source/fma_pkg.sv ====
package fma_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and constants
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int data_w = 16;                 // q8.8 word
    localparam int frac_w = 8;
    localparam int acc_w  = 34;                 // 16.16 plus headroom and sign guard
    localparam int tag_w  = 4;

    localparam logic [data_w-1:0] one_q = 16'h0100;     // 1.0

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operation and rounding codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        op_add   = 3'd0,
        op_sub   = 3'd1,
        op_mul   = 3'd2,
        op_madd  = 3'd3,
        op_msub  = 3'd4,
        op_nmadd = 3'd5,
        op_nmsub = 3'd6
    } fma_op_e;

    typedef enum logic [2:0] {
        rm_rne = 3'd0,                          // also used for unknown codes
        rm_rtz = 3'd1,
        rm_rdn = 3'd2,
        rm_rup = 3'd3
    } round_e;

    typedef struct packed {
        logic of;                               // overflow, result saturated
        logic nx;                               // inexact
    } fma_flags_t;

    typedef struct packed {
        logic signed [data_w-1:0] a;
        logic signed [data_w-1:0] b;
        logic signed [data_w-1:0] c;
    } lane_opnd_t;

    typedef struct packed {
        logic             valid;
        round_e           rm;
        logic [tag_w-1:0] tag;
    } pipe_ctl_t;

endpackage

// ==== source/fma_result.sv ====
`timescale 1ns/100ps

module fma_result #(
    parameter int num_lanes = 2
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         enable,
    input  logic [num_lanes-1:0][fma_pkg::acc_w-1:0]     acc,
    input  fma_pkg::pipe_ctl_t                           ctl_in,
    output logic [num_lanes-1:0][fma_pkg::data_w-1:0]    result,
    output fma_pkg::fma_flags_t [num_lanes-1:0]          flags,
    output logic                                         valid_out,
    output logic [fma_pkg::tag_w-1:0]                    tag_out
);

    localparam int rnd_w = fma_pkg::acc_w - fma_pkg::frac_w + 1;  // integer part plus guard

    localparam logic signed [rnd_w-1:0] max_q = 2 ** (fma_pkg::data_w - 1) - 1;
    localparam logic signed [rnd_w-1:0] min_q = -(2 ** (fma_pkg::data_w - 1));

    logic [num_lanes-1:0][fma_pkg::data_w-1:0] res_d;
    fma_pkg::fma_flags_t [num_lanes-1:0]       flg_d;

    always_comb begin
        logic signed [rnd_w-1:0]    q;
        logic [fma_pkg::frac_w-1:0] drop;
        logic                       inc;
        logic signed [rnd_w-1:0]    r;
        for (int i = 0; i < num_lanes; i++) begin
            q    = {acc[i][fma_pkg::acc_w-1], acc[i][fma_pkg::acc_w-1:fma_pkg::frac_w]};  // floor
            drop = acc[i][fma_pkg::frac_w-1:0];
            case (ctl_in.rm)
                fma_pkg::rm_rtz: inc = (|drop) & acc[i][fma_pkg::acc_w-1];  // up if negative
                fma_pkg::rm_rdn: inc = 1'b0;
                fma_pkg::rm_rup: inc = |drop;
                default:         inc = drop[fma_pkg::frac_w-1] &
                                       ((|drop[fma_pkg::frac_w-2:0]) | q[0]);  // ties to even
            endcase
            r           = q + rnd_w'(inc);
            flg_d[i].nx = |drop;
            flg_d[i].of = (r > max_q) | (r < min_q);
            if (r > max_q) begin
                res_d[i] = max_q[fma_pkg::data_w-1:0];
            end else if (r < min_q) begin
                res_d[i] = min_q[fma_pkg::data_w-1:0];
            end else begin
                res_d[i] = r[fma_pkg::data_w-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= 1'b0;
        end else if (enable) begin
            valid_out <= ctl_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result  <= res_d;
            flags   <= flg_d;
            tag_out <= ctl_in.tag;
        end
    end

endmodule

// ==== source/fma_unit.sv ====
`timescale 1ns/100ps

module fma_unit #(
    parameter int num_lanes   = 2,
    parameter int latency_mul = 3
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic                                         valid_in,
    output logic                                         ready_in,
    input  fma_pkg::fma_op_e                             op,
    input  logic [2:0]                                   frm,
    input  logic [fma_pkg::tag_w-1:0]                    tag_in,
    input  logic [num_lanes-1:0][fma_pkg::data_w-1:0]    dataa,
    input  logic [num_lanes-1:0][fma_pkg::data_w-1:0]    datab,
    input  logic [num_lanes-1:0][fma_pkg::data_w-1:0]    datac,
    input  logic                                         ready_out,
    output logic                                         valid_out,
    output logic [num_lanes-1:0][fma_pkg::data_w-1:0]    result,
    output fma_pkg::fma_flags_t [num_lanes-1:0]          flags,
    output logic [fma_pkg::tag_w-1:0]                    tag_out
);

    logic                                     stall;
    logic                                     enable;
    fma_pkg::lane_opnd_t [num_lanes-1:0]      opnd;
    fma_pkg::pipe_ctl_t                       dec_ctl;
    logic [num_lanes-1:0][fma_pkg::acc_w-1:0] acc;
    fma_pkg::pipe_ctl_t                       exe_ctl;

    // global back-pressure, whole pipe freezes
    assign stall    = valid_out & ~ready_out;
    assign enable   = ~stall;
    assign ready_in = enable;

    fma_decode #(.num_lanes(num_lanes)) u_decode (
        .clk(clk), .rst(rst), .enable(enable),
        .valid_in(valid_in), .op(op), .frm(frm), .tag_in(tag_in),
        .dataa(dataa), .datab(datab), .datac(datac),
        .opnd(opnd), .ctl(dec_ctl)
    );

    fma_execute #(.num_lanes(num_lanes), .latency_mul(latency_mul)) u_execute (
        .clk(clk), .rst(rst), .enable(enable),
        .opnd_in(opnd), .ctl_in(dec_ctl), .acc(acc), .ctl_out(exe_ctl)
    );

    fma_result #(.num_lanes(num_lanes)) u_result (
        .clk(clk), .rst(rst), .enable(enable), .acc(acc), .ctl_in(exe_ctl),
        .result(result), .flags(flags), .valid_out(valid_out), .tag_out(tag_out)
    );

endmodule
